/* filelist.f */
+incdir+tb
logic/conv_data_pkg.sv
logic/loop_ctrl_pkg.sv
logic/pixel_bus_if.sv
logic/pixel_loader.sv
logic/loop_buffer.sv
logic/pointwise_mac.sv
logic/conv_loop_top.sv
tb/conv_loop_tb.sv

/* logic/conv_data_pkg.sv */
`default_nettype none

package conv_data_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Word widths

	localparam int PIXEL_W = 8;
	localparam int WEIGHT_W = 8;
	localparam int ACC_W = 24;

	// Full product of one pixel and one weight
	localparam int PROD_W = PIXEL_W + WEIGHT_W;

	////////////////////////////////////////////////////////////////////////////
	// Data types

	// Input feature map sample
	typedef logic signed [PIXEL_W-1:0] pixel_t;

	// Pointwise kernel coefficient
	typedef logic signed [WEIGHT_W-1:0] weight_t;

	// Sum over up to 16 input channels, no overflow
	typedef logic signed [ACC_W-1:0] acc_t;

endpackage

`default_nettype wire

/* logic/conv_loop_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_loop_top import conv_data_pkg::*; #(
	parameter int IMAGE_WIDTH = 4,
	parameter int CH_IN = 4,
	parameter int CH_OUT = 4,
	parameter int GAP_CYCLES = 3,
	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH,
	localparam int IDX_W = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1,
	localparam int CO_W = (CH_OUT > 1) ? $clog2(CH_OUT) : 1
) (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input pixel_t pixel_in,
	input logic weight_valid,
	input weight_t weight_in,
	output logic result_valid,
	output acc_t result,
	output logic [CO_W-1:0] result_ch,
	output logic [IDX_W-1:0] result_index,
	output logic busy,
	output logic drop_strobe
);

	localparam int MAP_SIZE = CH_IN * IMAGE_SIZE;
	localparam int ADDR_W = (MAP_SIZE > 1) ? $clog2(MAP_SIZE) : 1;

	// Loader to buffer
	logic wr_en;
	logic [ADDR_W-1:0] wr_addr;
	pixel_t wr_data;
	logic map_done;

	pixel_bus_if #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN(CH_IN),
		.CH_OUT(CH_OUT)
	) pix_bus ();

	pixel_loader #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN(CH_IN)
	) loader0 (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.busy(busy),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.map_done(map_done),
		.drop_strobe(drop_strobe)
	);

	loop_buffer #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN(CH_IN),
		.CH_OUT(CH_OUT),
		.GAP_CYCLES(GAP_CYCLES)
	) buffer0 (
		.clk(clk),
		.reset(reset),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.map_done(map_done),
		.busy(busy),
		.bus(pix_bus.src)
	);

	pointwise_mac #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN(CH_IN),
		.CH_OUT(CH_OUT)
	) mac0 (
		.clk(clk),
		.reset(reset),
		.weight_valid(weight_valid),
		.weight_in(weight_in),
		.bus(pix_bus.snk),
		.result_valid(result_valid),
		.result(result),
		.result_ch(result_ch),
		.result_index(result_index)
	);

endmodule

`default_nettype wire

/* logic/loop_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module loop_buffer import conv_data_pkg::*, loop_ctrl_pkg::*; #(
	parameter int IMAGE_WIDTH = 4,
	parameter int CH_IN = 4,
	parameter int CH_OUT = 4,
	parameter int GAP_CYCLES = 3,
	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH,
	localparam int MAP_SIZE = CH_IN * IMAGE_SIZE,
	localparam int ADDR_W = (MAP_SIZE > 1) ? $clog2(MAP_SIZE) : 1
) (
	input logic clk,
	input logic reset,
	input logic wr_en,
	input logic [ADDR_W-1:0] wr_addr,
	input pixel_t wr_data,
	input logic map_done,
	output logic busy,
	pixel_bus_if.src bus
);

	localparam int IDX_W = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;
	localparam int CI_W = (CH_IN > 1) ? $clog2(CH_IN) : 1;
	localparam int CO_W = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;
	localparam int GAP_W = (GAP_CYCLES > 1) ? $clog2(GAP_CYCLES) : 1;

	pixel_t mem [MAP_SIZE];

	replay_state_t state;
	logic [ADDR_W-1:0] rd_addr;
	logic [CO_W-1:0] out_ch;
	logic [GAP_W-1:0] gap_cnt;

	logic [CI_W-1:0] rd_ch;
	logic [IDX_W-1:0] rd_idx;

	// Output stage registers
	logic valid_q;
	pixel_t data_q;
	logic [CI_W-1:0] in_ch_q;
	logic [CO_W-1:0] out_ch_q;
	logic [IDX_W-1:0] index_q;
	logic last_in_q;

	// Map is stored channel-major, so the address splits directly
	assign rd_ch = CI_W'(rd_addr / IMAGE_SIZE);
	assign rd_idx = IDX_W'(rd_addr % IMAGE_SIZE);

	always_ff @(posedge clk) begin
		if (wr_en && state == LOAD) begin
			mem[wr_addr] <= wr_data;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Replay sequencer

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= LOAD;
			rd_addr <= '0;
			out_ch <= '0;
			gap_cnt <= '0;
		end else begin
			case (state)
				LOAD: begin
					if (map_done) begin
						state <= PASS;
						rd_addr <= '0;
						out_ch <= '0;
					end
				end
				PASS: begin
					if (rd_addr == ADDR_W'(MAP_SIZE - 1)) begin
						rd_addr <= '0;
						if (out_ch == CO_W'(CH_OUT - 1)) begin
							state <= LOAD;
						end else begin
							out_ch <= out_ch + 1'b1;
							// No gap at all when GAP_CYCLES is zero
							if (GAP_CYCLES > 0) begin
								state <= GAP;
								gap_cnt <= '0;
							end
						end
					end else begin
						rd_addr <= rd_addr + 1'b1;
					end
				end
				GAP: begin
					if (gap_cnt == GAP_W'(GAP_CYCLES - 1)) begin
						state <= PASS;
					end else begin
						gap_cnt <= gap_cnt + 1'b1;
					end
				end
				default: state <= LOAD;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read stage, tags follow the data one cycle after the address

	always_ff @(posedge clk) begin
		data_q <= mem[rd_addr];
		in_ch_q <= rd_ch;
		index_q <= rd_idx;
		out_ch_q <= out_ch;
		last_in_q <= (rd_ch == CI_W'(CH_IN - 1));
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= (state == PASS);
		end
	end

	// Held high until the final beat has left
	assign busy = (state != LOAD) || valid_q;

	assign bus.valid = valid_q;
	assign bus.data = data_q;
	assign bus.in_ch = in_ch_q;
	assign bus.out_ch = out_ch_q;
	assign bus.index = index_q;
	assign bus.last_in = last_in_q;

endmodule

`default_nettype wire

/* logic/loop_ctrl_pkg.sv */
`default_nettype none

package loop_ctrl_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Replay sequencer phases

	// LOAD  writes from the loader are taken
	// PASS  one read sweep per output channel
	// GAP   idle between two sweeps
	typedef enum logic [1:0] {
		LOAD = 2'd0,
		PASS = 2'd1,
		GAP  = 2'd2
	} replay_state_t;

endpackage

`default_nettype wire

/* logic/pixel_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface pixel_bus_if import conv_data_pkg::*; #(
	parameter int IMAGE_WIDTH = 4,
	parameter int CH_IN = 4,
	parameter int CH_OUT = 4
) ();

	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int IDX_W = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1;
	localparam int CI_W = (CH_IN > 1) ? $clog2(CH_IN) : 1;
	localparam int CO_W = (CH_OUT > 1) ? $clog2(CH_OUT) : 1;

	// One beat per cycle with valid high, no stall
	logic valid;
	pixel_t data;
	logic [CI_W-1:0] in_ch;
	logic [CO_W-1:0] out_ch;
	logic [IDX_W-1:0] index;
	logic last_in;

	modport src (output valid, data, in_ch, out_ch, index, last_in);
	modport snk (input valid, data, in_ch, out_ch, index, last_in);

endinterface

`default_nettype wire

/* logic/pixel_loader.sv */
`timescale 1ns/1ps
`default_nettype none

module pixel_loader import conv_data_pkg::*; #(
	parameter int IMAGE_WIDTH = 4,
	parameter int CH_IN = 4,
	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH,
	localparam int MAP_SIZE = CH_IN * IMAGE_SIZE,
	localparam int ADDR_W = (MAP_SIZE > 1) ? $clog2(MAP_SIZE) : 1
) (
	input logic clk,
	input logic reset,
	input logic pixel_valid,
	input pixel_t pixel_in,
	input logic busy,
	output logic wr_en,
	output logic [ADDR_W-1:0] wr_addr,
	output pixel_t wr_data,
	output logic map_done,
	output logic drop_strobe
);

	logic [ADDR_W-1:0] pix_cnt;
	logic take;
	logic last_pix;

	// Blocked while the buffer replays, and in the cycle before busy rises
	assign take = pixel_valid && !busy && !map_done;
	assign last_pix = (pix_cnt == ADDR_W'(MAP_SIZE - 1));

	always_ff @(posedge clk) begin
		if (reset) begin
			pix_cnt <= '0;
			wr_en <= 1'b0;
			map_done <= 1'b0;
			drop_strobe <= 1'b0;
		end else begin
			wr_en <= take;
			map_done <= take && last_pix;
			drop_strobe <= pixel_valid && !take;
			if (take) begin
				// Wrap for the next map
				pix_cnt <= last_pix ? '0 : pix_cnt + 1'b1;
			end
		end
	end

	// Write payload, one cycle behind the accepted pixel
	always_ff @(posedge clk) begin
		if (take) begin
			wr_addr <= pix_cnt;
			wr_data <= pixel_in;
		end
	end

endmodule

`default_nettype wire

/* logic/pointwise_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module pointwise_mac import conv_data_pkg::*; #(
	parameter int IMAGE_WIDTH = 4,
	parameter int CH_IN = 4,
	parameter int CH_OUT = 4,
	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH,
	localparam int IDX_W = (IMAGE_SIZE > 1) ? $clog2(IMAGE_SIZE) : 1,
	localparam int CO_W = (CH_OUT > 1) ? $clog2(CH_OUT) : 1
) (
	input logic clk,
	input logic reset,
	input logic weight_valid,
	input weight_t weight_in,
	pixel_bus_if.snk bus,
	output logic result_valid,
	output acc_t result,
	output logic [CO_W-1:0] result_ch,
	output logic [IDX_W-1:0] result_index
);

	localparam int W_SIZE = CH_OUT * CH_IN;
	localparam int W_ADDR_W = (W_SIZE > 1) ? $clog2(W_SIZE) : 1;

	weight_t weight_mem [W_SIZE];
	acc_t acc_mem [IMAGE_SIZE];

	logic [W_ADDR_W-1:0] w_wr_addr;
	logic [W_ADDR_W-1:0] w_rd_addr;
	logic signed [PROD_W-1:0] product;
	acc_t acc_base;
	acc_t acc_sum;
	logic beat_last;

	////////////////////////////////////////////////////////////////////////////
	// Weight store, output channel major

	always_ff @(posedge clk) begin
		if (reset) begin
			w_wr_addr <= '0;
		end else if (weight_valid) begin
			w_wr_addr <= (w_wr_addr == W_ADDR_W'(W_SIZE - 1)) ? '0 : w_wr_addr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (weight_valid) begin
			weight_mem[w_wr_addr] <= weight_in;
		end
	end

	assign w_rd_addr = W_ADDR_W'(bus.out_ch * CH_IN + bus.in_ch);

	////////////////////////////////////////////////////////////////////////////
	// Multiply and accumulate per pixel position

	always_comb begin
		product = bus.data * weight_mem[w_rd_addr];
		// Channel zero starts a fresh sum
		acc_base = (bus.in_ch == '0) ? '0 : acc_mem[bus.index];
		acc_sum = acc_base + acc_t'(product);
	end

	assign beat_last = bus.valid && bus.last_in;

	always_ff @(posedge clk) begin
		if (bus.valid) begin
			acc_mem[bus.index] <= acc_sum;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= beat_last;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_last) begin
			result <= acc_sum;
			result_ch <= bus.out_ch;
			result_index <= bus.index;
		end
	end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the convolution stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -j 0 \
	--top-module conv_loop_tb \
	-f filelist.f \
	-o conv_loop_sim

./obj_dir/conv_loop_sim | tee sim.log

if grep -qx "Everything OK" sim.log; then
	echo "Simulation passed"
	exit 0
else
	echo "Simulation failed"
	exit 1
fi

/* tb/conv_loop_tests.svh */
////////////////////////////////////////////////////////////////////////////
// Directed tests

task automatic fill_random_pixels();
	for (int i = 0; i < MAP_SIZE; i++) begin
		pix_map[i] = pixel_t'($urandom);
	end
endtask

task automatic fill_random_weights();
	for (int i = 0; i < W_SIZE; i++) begin
		wts[i] = weight_t'($urandom);
	end
endtask

task automatic test_identity();
	int errs;
	errs = errors;
	apply_reset();
	for (int i = 0; i < W_SIZE; i++) begin
		wts[i] = (i / CH_IN == i % CH_IN) ? weight_t'(1) : weight_t'(0);
	end
	fill_random_pixels();
	load_weights();
	load_map();
	wait_results(N_RESULTS);
	// Output channel c passes input channel c, so result k is stored pixel k
	for (int k = 0; k < N_RESULTS && k < res_q.size(); k++) begin
		compare_acc("result", res_q[k], acc_t'(pix_map[k]));
	end
	check_results();
	report_test("identity weights", errs);
endtask

// Also covers burst spacing through check_results
task automatic test_random_map();
	int errs;
	errs = errors;
	apply_reset();
	fill_random_weights();
	fill_random_pixels();
	load_weights();
	load_map();
	check_results();
	report_test("random map", errs);
endtask

task automatic test_drop_while_busy();
	int errs;
	errs = errors;
	apply_reset();
	fill_random_weights();
	fill_random_pixels();
	load_weights();
	load_map();
	wait_busy(1'b1);
	offer_pixels(5);
	check_results();
	compare_tag("drop_strobe count", drop_cnt, 5);
	// Second map must not see the dropped pixels
	wait_busy(1'b0);
	fill_random_pixels();
	load_map();
	check_results();
	report_test("drop while busy", errs);
endtask

task automatic test_busy_and_reload();
	int errs;
	errs = errors;
	apply_reset();
	compare_bit("busy", busy, 1'b0);
	fill_random_weights();
	fill_random_pixels();
	load_weights();
	load_map();
	wait_busy(1'b1);
	wait_results(N_RESULTS);
	if (busy_q.size() == N_RESULTS) begin
		compare_bit("busy at first result", busy_q[0], 1'b1);
		compare_bit("busy at last result", busy_q[N_RESULTS - 1], 1'b0);
	end
	check_results();
	// New weights and map, no reset in between
	wait_busy(1'b0);
	fill_random_weights();
	fill_random_pixels();
	load_weights();
	load_map();
	check_results();
	report_test("busy and reload", errs);
endtask

task automatic test_reset_in_replay();
	int errs;
	errs = errors;
	apply_reset();
	fill_random_weights();
	fill_random_pixels();
	load_weights();
	load_map();
	wait_results(5);
	apply_reset();
	compare_bit("result_valid", result_valid, 1'b0);
	compare_bit("busy", busy, 1'b0);
	compare_bit("drop_strobe", drop_strobe, 1'b0);
	fill_random_weights();
	fill_random_pixels();
	load_weights();
	load_map();
	check_results();
	report_test("reset during replay", errs);
endtask

/* tb/conv_loop_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_loop_tb import conv_data_pkg::*; ();

	localparam int IMAGE_WIDTH = 4;
	localparam int CH_IN = 4;
	localparam int CH_OUT = 4;
	localparam int GAP_CYCLES = 3;
	localparam int IMAGE_SIZE = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int MAP_SIZE = CH_IN * IMAGE_SIZE;
	localparam int W_SIZE = CH_OUT * CH_IN;
	localparam int N_RESULTS = CH_OUT * IMAGE_SIZE;
	localparam int IDX_W = $clog2(IMAGE_SIZE);
	localparam int CO_W = $clog2(CH_OUT);
	localparam int TIMEOUT = 2000;

	logic clk;
	logic reset;
	logic pixel_valid;
	pixel_t pixel_in;
	logic weight_valid;
	weight_t weight_in;
	logic result_valid;
	acc_t result;
	logic [CO_W-1:0] result_ch;
	logic [IDX_W-1:0] result_index;
	logic busy;
	logic drop_strobe;

	// Stimulus of the current map
	pixel_t pix_map [MAP_SIZE];
	weight_t wts [W_SIZE];

	// Collected results, in arrival order
	acc_t res_q [$];
	int ch_q [$];
	int idx_q [$];
	int cyc_q [$];
	logic busy_q [$];

	int cycle;
	int drop_cnt;
	int errors;
	int checks;
	int tests;

	conv_loop_top #(
		.IMAGE_WIDTH(IMAGE_WIDTH),
		.CH_IN(CH_IN),
		.CH_OUT(CH_OUT),
		.GAP_CYCLES(GAP_CYCLES)
	) dut0 (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.pixel_in(pixel_in),
		.weight_valid(weight_valid),
		.weight_in(weight_in),
		.result_valid(result_valid),
		.result(result),
		.result_ch(result_ch),
		.result_index(result_index),
		.busy(busy),
		.drop_strobe(drop_strobe)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Outputs sampled mid-cycle
	always @(negedge clk) begin
		cycle++;
		if (result_valid) begin
			res_q.push_back(result);
			ch_q.push_back(int'(result_ch));
			idx_q.push_back(int'(result_index));
			cyc_q.push_back(cycle);
			busy_q.push_back(busy);
		end
		if (drop_strobe) begin
			drop_cnt++;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic compare_acc(input string name, input acc_t got, input acc_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_tag(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("FAIL %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAIL %0d ns %s: got %b, expected %b", $time, name, got, exp);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model and drivers

	// Sum over input channels of weight times pixel
	function automatic acc_t expected_result(input int co, input int idx);
		acc_t sum;
		sum = '0;
		for (int ci = 0; ci < CH_IN; ci++) begin
			sum = sum + acc_t'(wts[co * CH_IN + ci]) * acc_t'(pix_map[ci * IMAGE_SIZE + idx]);
		end
		return sum;
	endfunction

	task automatic clear_results();
		res_q.delete();
		ch_q.delete();
		idx_q.delete();
		cyc_q.delete();
		busy_q.delete();
	endtask

	task automatic apply_reset();
		@(negedge clk);
		reset = 1'b1;
		pixel_valid = 1'b0;
		weight_valid = 1'b0;
		repeat (3) @(negedge clk);
		reset = 1'b0;
		clear_results();
		drop_cnt = 0;
	endtask

	task automatic load_weights();
		for (int i = 0; i < W_SIZE; i++) begin
			@(negedge clk);
			weight_valid = 1'b1;
			weight_in = wts[i];
		end
		@(negedge clk);
		weight_valid = 1'b0;
	endtask

	task automatic load_map();
		for (int i = 0; i < MAP_SIZE; i++) begin
			@(negedge clk);
			pixel_valid = 1'b1;
			pixel_in = pix_map[i];
		end
		@(negedge clk);
		pixel_valid = 1'b0;
	endtask

	// Pixels offered regardless of busy
	task automatic offer_pixels(input int count);
		for (int i = 0; i < count; i++) begin
			@(negedge clk);
			pixel_valid = 1'b1;
			pixel_in = pixel_t'($urandom);
		end
		@(negedge clk);
		pixel_valid = 1'b0;
	endtask

	task automatic wait_results(input int count);
		int t;
		t = 0;
		while (res_q.size() < count && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		if (res_q.size() < count) begin
			errors++;
			$display("Timed out waiting for %0d results, only %0d arrived", count, res_q.size());
		end
	endtask

	task automatic wait_busy(input logic level);
		int t;
		t = 0;
		while (busy !== level && t < TIMEOUT) begin
			@(negedge clk);
			t++;
		end
		if (busy !== level) begin
			errors++;
			$display("Timed out waiting for busy to become %b", level);
		end
	endtask

	// Order, values and spacing of one full set of results
	task automatic check_results();
		int exp_ch;
		int exp_idx;
		int exp_gap;
		wait_results(N_RESULTS);
		for (int k = 0; k < N_RESULTS && k < res_q.size(); k++) begin
			exp_ch = k / IMAGE_SIZE;
			exp_idx = k % IMAGE_SIZE;
			compare_tag("result_ch", ch_q[k], exp_ch);
			compare_tag("result_index", idx_q[k], exp_idx);
			compare_acc("result", res_q[k], expected_result(exp_ch, exp_idx));
			if (k > 0) begin
				exp_gap = (exp_idx == 0) ? GAP_CYCLES + (CH_IN - 1) * IMAGE_SIZE + 1 : 1;
				compare_tag("result_valid spacing", cyc_q[k] - cyc_q[k - 1], exp_gap);
			end
		end
		clear_results();
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		$display("Test %s: %s", name, (errors == errs_before) ? "passed" : "failed");
	endtask

	`include "conv_loop_tests.svh"

	initial begin
		reset = 1'b1;
		pixel_valid = 1'b0;
		pixel_in = '0;
		weight_valid = 1'b0;
		weight_in = '0;
		errors = 0;
		checks = 0;
		tests = 0;
		void'($urandom(84));

		apply_reset();
		test_identity();
		test_random_map();
		test_drop_while_busy();
		test_busy_and_reload();
		test_reset_in_replay();

		$display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
